//--- rtl/des_params.svh
`ifndef DES_PARAMS_SVH
`define DES_PARAMS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// DES datapath sizes.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// Plaintext and ciphertext block.
`define DES_BLOCK_W 64

// One Feistel half, L or R.
`define DES_HALF_W 32

// Key including parity bits.
`define DES_KEY_W 64

// Key schedule halves C and D.
`define DES_CD_W 28

`define DES_SUBKEY_W 48
`define DES_ROUNDS 16
`define DES_ROUND_IDX_W 4

`endif

//--- rtl/des_pkg.sv
`include "des_params.svh"

package des_pkg;

    typedef logic [`DES_BLOCK_W-1:0]  block_t;
    typedef logic [`DES_HALF_W-1:0]   half_t;
    typedef logic [`DES_SUBKEY_W-1:0] subkey_t;
    typedef logic [2*`DES_CD_W-1:0]   cd_pair_t;

    typedef struct packed {
        logic    load;
        logic    valid;
        logic    last;
        subkey_t subkey;
    } round_ctl_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Tables, bit numbers 1-based from the MSB as in FIPS 46.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam logic [1:0] SHIFT_TAB [`DES_ROUNDS] = '{
        2'd1, 2'd1, 2'd2, 2'd2, 2'd2, 2'd2, 2'd2, 2'd2,
        2'd1, 2'd2, 2'd2, 2'd2, 2'd2, 2'd2, 2'd2, 2'd1};

    localparam int IP_TAB [64] = '{
        58, 50, 42, 34, 26, 18, 10, 2, 60, 52, 44, 36, 28, 20, 12, 4,
        62, 54, 46, 38, 30, 22, 14, 6, 64, 56, 48, 40, 32, 24, 16, 8,
        57, 49, 41, 33, 25, 17,  9, 1, 59, 51, 43, 35, 27, 19, 11, 3,
        61, 53, 45, 37, 29, 21, 13, 5, 63, 55, 47, 39, 31, 23, 15, 7};

    localparam int FP_TAB [64] = '{
        40, 8, 48, 16, 56, 24, 64, 32, 39, 7, 47, 15, 55, 23, 63, 31,
        38, 6, 46, 14, 54, 22, 62, 30, 37, 5, 45, 13, 53, 21, 61, 29,
        36, 4, 44, 12, 52, 20, 60, 28, 35, 3, 43, 11, 51, 19, 59, 27,
        34, 2, 42, 10, 50, 18, 58, 26, 33, 1, 41,  9, 49, 17, 57, 25};

    localparam int PC1_TAB [56] = '{
        57, 49, 41, 33, 25, 17,  9,  1, 58, 50, 42, 34, 26, 18,
        10,  2, 59, 51, 43, 35, 27, 19, 11,  3, 60, 52, 44, 36,
        63, 55, 47, 39, 31, 23, 15,  7, 62, 54, 46, 38, 30, 22,
        14,  6, 61, 53, 45, 37, 29, 21, 13,  5, 28, 20, 12,  4};

    localparam int PC2_TAB [48] = '{
        14, 17, 11, 24,  1,  5,  3, 28, 15,  6, 21, 10, 23, 19, 12,  4,
        26,  8, 16,  7, 27, 20, 13,  2, 41, 52, 31, 37, 47, 55, 30, 40,
        51, 45, 33, 48, 44, 49, 39, 56, 34, 53, 46, 42, 50, 36, 29, 32};

    localparam int E_TAB [48] = '{
        32,  1,  2,  3,  4,  5,  4,  5,  6,  7,  8,  9,  8,  9, 10, 11,
        12, 13, 12, 13, 14, 15, 16, 17, 16, 17, 18, 19, 20, 21, 20, 21,
        22, 23, 24, 25, 24, 25, 26, 27, 28, 29, 28, 29, 30, 31, 32,  1};

    localparam int P_TAB [32] = '{
        16,  7, 20, 21, 29, 12, 28, 17,  1, 15, 23, 26,  5, 18, 31, 10,
         2,  8, 24, 14, 32, 27,  3,  9, 19, 13, 30,  6, 22, 11,  4, 25};

    // One box per entry, four rows of sixteen nibbles, first entry in the top nibble.
    localparam logic [255:0] SBOX_TAB [8] = '{
        256'hE4D12FB83A6C5907_0F74E2D1A6CB9538_41E8D62BFC973A50_FC8249175B3EA06D,
        256'hF18E6B34972DC05A_3D47F28EC01A69B5_0E7BA4D158C6932F_D8A13F42B67C05E9,
        256'hA09E63F51DC7B428_D709346A285ECBF1_D6498F30B12C5AE7_1AD069874FE3B52C,
        256'h7DE3069A1285BC4F_D8B56F03472C1AE9_A690CB7DF13E5284_3F06A1D8945BC72E,
        256'h2C417AB6853FD0E9_EB2C47D150FA3986_421BAD78F9C5630E_B8C71E2D6F09A453,
        256'hC1AF92680D34E75B_AF427C9561DE0B38_9EF528C3704A1DB6_432C95FABE17608D,
        256'h4B2EF08D3C975A61_D0B7491AE35C2F86_14BDC37EAF680592_6BD814A7950FE23C,
        256'hD2846FB1A93E50C7_1FD8A374C56B0E92_7B419CE206ADF358_21E74A8DFC90356B};

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Fixed permutations.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic block_t ip_perm(block_t din);
        block_t dout;
        for (int i = 0; i < 64; i++)
            dout[`DES_BLOCK_W-1-i] = din[`DES_BLOCK_W-IP_TAB[i]];
        return dout;
    endfunction

    function automatic block_t fp_perm(block_t din);
        block_t dout;
        for (int i = 0; i < 64; i++)
            dout[`DES_BLOCK_W-1-i] = din[`DES_BLOCK_W-FP_TAB[i]];
        return dout;
    endfunction

    // Parity bits drop out here.
    function automatic cd_pair_t pc1_perm(logic [`DES_KEY_W-1:0] din);
        cd_pair_t dout;
        for (int i = 0; i < 56; i++)
            dout[2*`DES_CD_W-1-i] = din[`DES_KEY_W-PC1_TAB[i]];
        return dout;
    endfunction

    function automatic subkey_t pc2_perm(cd_pair_t din);
        subkey_t dout;
        for (int i = 0; i < 48; i++)
            dout[`DES_SUBKEY_W-1-i] = din[2*`DES_CD_W-PC2_TAB[i]];
        return dout;
    endfunction

    function automatic subkey_t e_expand(half_t din);
        subkey_t dout;
        for (int i = 0; i < 48; i++)
            dout[`DES_SUBKEY_W-1-i] = din[`DES_HALF_W-E_TAB[i]];
        return dout;
    endfunction

    function automatic half_t p_perm(half_t din);
        half_t dout;
        for (int i = 0; i < 32; i++)
            dout[`DES_HALF_W-1-i] = din[`DES_HALF_W-P_TAB[i]];
        return dout;
    endfunction

    // Row from the outer bits, column from the inner four.
    function automatic logic [3:0] sbox_lookup(int unsigned box, logic [5:0] din);
        int unsigned idx;
        idx = {din[5], din[0], din[4:1]};
        return SBOX_TAB[box][255-4*idx -: 4];
    endfunction

endpackage

//--- rtl/des_key_sched.sv
`timescale 1ns/10ps

`include "des_params.svh"

module des_key_sched
    import des_pkg::*;
(
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  start,
    input  logic [`DES_KEY_W-1:0] key,
    output round_ctl_t            round_ctl,
    output logic                  busy
);

    logic                        accept;
    logic                        last_round;
    logic [`DES_ROUND_IDX_W-1:0] round_idx;
    logic [1:0]                  shift;
    cd_pair_t                    pc1;
    logic [`DES_CD_W-1:0]        c_q;
    logic [`DES_CD_W-1:0]        d_q;
    logic [`DES_CD_W-1:0]        c_rot;
    logic [`DES_CD_W-1:0]        d_rot;

    function automatic logic [`DES_CD_W-1:0] rol_cd(logic [`DES_CD_W-1:0] v, logic [1:0] n);
        if (n == 2'd2)
            return {v[`DES_CD_W-3:0], v[`DES_CD_W-1 -: 2]};
        return {v[`DES_CD_W-2:0], v[`DES_CD_W-1]};
    endfunction

    // Start is dropped while a block is in flight.
    assign accept = start & ~busy;

    // Counter holds the round number minus one.
    assign last_round = busy && (round_idx == `DES_ROUND_IDX_W'(`DES_ROUNDS - 1));
    assign shift      = SHIFT_TAB[round_idx];
    assign pc1        = pc1_perm(key);
    assign c_rot      = rol_cd(c_q, shift);
    assign d_rot      = rol_cd(d_q, shift);

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            busy      <= 1'b0;
            round_idx <= '0;
        end
        else if (accept)
        begin
            busy      <= 1'b1;
            round_idx <= '0;
        end
        else if (busy)
        begin
            round_idx <= round_idx + 1'b1;
            if (last_round)
                busy <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            c_q <= pc1[2*`DES_CD_W-1 -: `DES_CD_W];
            d_q <= pc1[`DES_CD_W-1:0];
        end
        else if (busy)
        begin
            c_q <= c_rot;
            d_q <= d_rot;
        end
    end

    always_comb
    begin
        round_ctl.load   = accept;
        round_ctl.valid  = busy;
        round_ctl.last   = last_round;
        round_ctl.subkey = pc2_perm({c_rot, d_rot});
    end

endmodule

//--- rtl/des_block_state.sv
`timescale 1ns/10ps

`include "des_params.svh"

module des_block_state
    import des_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  block_t     msg,
    input  round_ctl_t round_ctl,
    input  half_t      f_out,
    output half_t      r_half,
    output block_t     result,
    output logic       done
);

    half_t  l_q;
    half_t  r_q;
    half_t  r_next;
    block_t ip_msg;
    logic   finish;

    assign ip_msg = ip_perm(msg);
    assign r_next = l_q ^ f_out;
    assign finish = round_ctl.valid & round_ctl.last;
    assign r_half = r_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Feistel halves.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk)
    begin
        if (round_ctl.load)
        begin
            l_q <= ip_msg[`DES_BLOCK_W-1 -: `DES_HALF_W];
            r_q <= ip_msg[`DES_HALF_W-1:0];
        end
        else if (round_ctl.valid)
        begin
            l_q <= r_q;
            r_q <= r_next;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Output register and done pulse.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            result <= '0;
            done   <= 1'b0;
        end
        else
        begin
            done <= finish;
            // Round 16 output goes out swapped, R16 then L16.
            if (finish)
                result <= fp_perm({r_next, r_q});
        end
    end

endmodule

//--- rtl/des_round_f.sv
`timescale 1ns/10ps

`include "des_params.svh"

module des_round_f
    import des_pkg::*;
(
    input  half_t   r_half,
    input  subkey_t subkey,
    output half_t   f_out
);

    subkey_t expanded;
    subkey_t mixed;
    half_t   s_out;

    assign expanded = e_expand(r_half);
    assign mixed    = expanded ^ subkey;

    // Eight boxes, box 1 on the top six bits.
    always_comb
    begin
        s_out = '0;
        for (int b = 0; b < 8; b++)
            s_out[`DES_HALF_W-1-4*b -: 4] = sbox_lookup(b, mixed[`DES_SUBKEY_W-1-6*b -: 6]);
    end

    assign f_out = p_perm(s_out);

endmodule

//--- rtl/des_core.sv
`timescale 1ns/10ps

`include "des_params.svh"

module des_core
    import des_pkg::*;
(
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  start,
    input  logic [`DES_KEY_W-1:0] key,
    input  block_t                msg,
    output block_t                result,
    output logic                  busy,
    output logic                  done
);

    round_ctl_t round_ctl;
    half_t      r_half;
    half_t      f_out;

    // Round control and subkeys.
    des_key_sched u_key_sched (
        .clk       (clk),
        .arst_n    (arst_n),
        .start     (start),
        .key       (key),
        .round_ctl (round_ctl),
        .busy      (busy)
    );

    des_block_state u_block_state (
        .clk       (clk),
        .arst_n    (arst_n),
        .msg       (msg),
        .round_ctl (round_ctl),
        .f_out     (f_out),
        .r_half    (r_half),
        .result    (result),
        .done      (done)
    );

    des_round_f u_round_f (
        .r_half (r_half),
        .subkey (round_ctl.subkey),
        .f_out  (f_out)
    );

endmodule

//--- test/des_sva.sv
`timescale 1ns/10ps

module des_sva (
    input logic clk,
    input logic arst_n,
    input logic start,
    input logic busy,
    input logic done
);

    // Done is a single-cycle pulse.
    done_one_cycle: assert property (@(posedge clk) disable iff (!arst_n)
        done |=> !done)
        else $error("done held high for more than one cycle");

    // Busy drops at the edge that raises done.
    done_after_busy: assert property (@(posedge clk) disable iff (!arst_n)
        done |-> !busy && $past(busy))
        else $error("done without a preceding busy period");

    start_accepted: assert property (@(posedge clk) disable iff (!arst_n)
        start && !busy |=> busy)
        else $error("start while idle did not raise busy");

    quiet_in_reset: assert property (@(posedge clk)
        !arst_n |-> !busy && !done)
        else $error("busy or done high during reset");

endmodule

bind des_core des_sva u_des_sva (
    .clk    (clk),
    .arst_n (arst_n),
    .start  (start),
    .busy   (busy),
    .done   (done)
);

//--- test/des_tb.sv
`timescale 1ns/10ps

`include "des_params.svh"

module des_tb
    import des_pkg::*;
();

    logic                  clk;
    logic                  arst_n;
    logic                  start;
    logic [`DES_KEY_W-1:0] key;
    block_t                msg;
    block_t                result;
    logic                  busy;
    logic                  done;

    int unsigned cycle_cnt = 0;
    int unsigned done_cnt = 0;
    int unsigned launched = 0;
    block_t      exp_q[$];
    int unsigned due_q[$];
    string       name_q[$];

    des_core u_des_core (
        .clk    (clk),
        .arst_n (arst_n),
        .start  (start),
        .key    (key),
        .msg    (msg),
        .result (result),
        .busy   (busy),
        .done   (done)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk)
        cycle_cnt <= cycle_cnt + 1;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference model and checking.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic block_t des_ref(logic [`DES_KEY_W-1:0] k, block_t m);
        cd_pair_t             cd;
        logic [`DES_CD_W-1:0] c;
        logic [`DES_CD_W-1:0] d;
        half_t                l;
        half_t                r;
        half_t                s;
        half_t                t;
        subkey_t              x;
        block_t               b;
        b = ip_perm(m);
        l = b[63:32];
        r = b[31:0];
        cd = pc1_perm(k);
        c = cd[55:28];
        d = cd[27:0];
        for (int i = 0; i < `DES_ROUNDS; i++)
        begin
            for (int n = 0; n < SHIFT_TAB[i]; n++)
            begin
                c = {c[26:0], c[27]};
                d = {d[26:0], d[27]};
            end
            x = e_expand(r) ^ pc2_perm({c, d});
            for (int j = 0; j < 8; j++)
                s[31-4*j -: 4] = sbox_lookup(j, x[47-6*j -: 6]);
            t = r;
            r = l ^ p_perm(s);
            l = t;
        end
        return fp_perm({r, l});
    endfunction

    task automatic abort_run(string why);
        $display("%s", why);
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(string name, logic [63:0] expected, logic [63:0] actual);
        if (expected !== actual)
            abort_run($sformatf("ERR %s expected %h actual %h", name, expected, actual));
    endtask

    // Each done pops the oldest block in flight.
    always @(negedge clk)
    begin
        if (arst_n && done)
        begin
            if (exp_q.size() == 0)
                abort_run("done pulsed while no block was in flight");
            check_value({name_q[0], " result"}, exp_q[0], result);
            check_value({name_q[0], " latency"}, 64'(due_q[0]), 64'(cycle_cnt));
            exp_q.delete(0);
            due_q.delete(0);
            name_q.delete(0);
            done_cnt++;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus, entered and left on a falling edge.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic launch(string name, logic [`DES_KEY_W-1:0] k, block_t m);
        key = k;
        msg = m;
        start = 1'b1;
        exp_q.push_back(des_ref(k, m));
        // Sampling edge plus sixteen rounds.
        due_q.push_back(cycle_cnt + 17);
        name_q.push_back(name);
        launched++;
        @(negedge clk);
        start = 1'b0;
    endtask

    task automatic wait_done(string name);
        int     n;
        block_t held;
        n = 0;
        held = result;
        while (!done && n < 40)
        begin
            check_value({name, " hold"}, held, result);
            check_value({name, " busy"}, 64'd1, 64'(busy));
            @(negedge clk);
            n++;
        end
        if (!done)
            abort_run({name, ": done never came within 40 cycles"});
        check_value({name, " busy at done"}, 64'd0, 64'(busy));
    endtask

    initial
    begin
        logic [`DES_KEY_W-1:0] k;
        block_t                m;
        start = 1'b0;
        key = '0;
        msg = '0;
        arst_n = 1'b0;
        void'($urandom(30));
        repeat (16) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);

        check_value("reset result", '0, result);
        check_value("reset busy", 64'd0, 64'(busy));
        check_value("reset done", 64'd0, 64'(done));

        // Standard worked example.
        launch("known answer", 64'h133457799BBCDFF1, 64'h0123456789ABCDEF);
        wait_done("known answer");
        check_value("known answer literal", 64'h85E813540F0AB405, result);
        @(negedge clk);

        for (int i = 0; i < 20; i++)
        begin
            k = {$urandom, $urandom};
            m = {$urandom, $urandom};
            launch($sformatf("random %0d", i), k, m);
            wait_done($sformatf("random %0d", i));
            repeat ($urandom % 3 + 1) @(negedge clk);
        end

        // Second start mid-block must be dropped.
        launch("ignored start", {$urandom, $urandom}, {$urandom, $urandom});
        repeat (4) @(negedge clk);
        key = {$urandom, $urandom};
        msg = {$urandom, $urandom};
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        wait_done("ignored start");
        repeat (20) @(negedge clk);
        check_value("ignored start done count", 64'(launched), 64'(done_cnt));

        // New start issued in the done cycle.
        launch("back to back 0", {$urandom, $urandom}, {$urandom, $urandom});
        wait_done("back to back 0");
        launch("back to back 1", {$urandom, $urandom}, {$urandom, $urandom});
        wait_done("back to back 1");
        launch("back to back 2", {$urandom, $urandom}, {$urandom, $urandom});
        wait_done("back to back 2");
        repeat (20) @(negedge clk);

        check_value("final done count", 64'(launched), 64'(done_cnt));

        $display("PASS: all tests");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+rtl
rtl/des_pkg.sv
rtl/des_key_sched.sv
rtl/des_block_state.sv
rtl/des_round_f.sv
rtl/des_core.sv
test/des_sva.sv
test/des_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module des_tb -f verilog.f -o des_tb_sim

./obj_dir/des_tb_sim
